/* code_lock.f */
source/code_lock_pkg.sv
source/key_decoder.sv
source/entry_controller.sv
source/lockout_timer.sv
source/buzzer_driver.sv
source/code_lock.sv
tests/tb_code_lock.sv

/* tests/tb_code_lock.sv */
`timescale 1ns/10ps

module tb_code_lock import code_lock_pkg::*; ();

    localparam display_t tb_passcode = 12'h905;
    localparam int       tb_tries    = 3;
    localparam int       tb_secs     = 3;
    localparam int       tb_tps      = 20;
    localparam key_t     lock_over   = 4'd14;  // pseudo key marking the end of lockout
    localparam int       settle_max  = 20;

    logic        clk;
    logic        arst_n;
    logic [15:0] keys;
    display_t    display;
    logic        unlocked;
    logic        locked_out;
    logic [2:0]  tries;
    logic        buzzer;

    key_t        presses[$];  // every press the DUT has decoded so far
    int          exp_secs;
    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          tests;
    int          test_errors;

    code_lock #(
        .passcode      (tb_passcode),
        .max_tries     (tb_tries),
        .lockout_secs  (tb_secs),
        .ticks_per_sec (tb_tps),
        .click_half    (2),
        .click_len     (12),
        .pass_half     (3),
        .pass_len      (24),
        .fail_half     (4),
        .fail_len      (30)
    ) u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .keys       (keys),
        .display    (display),
        .unlocked   (unlocked),
        .locked_out (locked_out),
        .tries      (tries),
        .buzzer     (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [7:0] to_bcd(input int v);
        return {4'(v / 10), 4'(v % 10)};
    endfunction

    function automatic logic [15:0] key_vector(input key_t k);
        case (k)
            4'd0:       return 16'h0008;
            4'd1:       return 16'h0080;
            4'd2:       return 16'h0040;
            4'd3:       return 16'h0020;
            4'd4:       return 16'h0800;
            4'd5:       return 16'h0400;
            4'd6:       return 16'h0200;
            4'd7:       return 16'h8000;
            4'd8:       return 16'h4000;
            4'd9:       return 16'h2000;
            key_enter:  return 16'h0001;
            key_cancel: return 16'h1000;
            key_clear:  return 16'h0100;
            default:    return 16'h0000;
        endcase
    endfunction

    // replays the presses into the expected {display, unlocked, locked_out, tries}
    function automatic logic [16:0] expected_state(input int secs);
        lock_state_t st;
        display_t    shown;
        display_t    disp;
        int          ndig;
        int          n_tries;
        st      = st_entry;
        shown   = disp_blank;
        ndig    = 0;
        n_tries = 0;
        foreach (presses[i]) begin
            if (st == st_entry) begin
                if (presses[i] <= 4'd9) begin
                    if (ndig < 3) begin
                        shown = {shown[7:0], presses[i]};
                        ndig++;
                    end
                end else if (presses[i] == key_enter) begin
                    if (ndig == 3 && shown == tb_passcode) begin
                        st = st_open;
                    end else if (n_tries + 1 >= tb_tries) begin
                        st      = st_lockout;
                        n_tries = 0;
                    end else begin
                        n_tries++;
                    end
                    shown = disp_blank;
                    ndig  = 0;
                end else if (presses[i] == key_cancel || presses[i] == key_clear) begin
                    shown = disp_blank;
                    ndig  = 0;
                    if (presses[i] == key_clear) begin
                        n_tries = 0;
                    end
                end
            end else if (st == st_open && presses[i] == key_clear) begin
                st      = st_entry;
                n_tries = 0;
            end else if (st == st_lockout && presses[i] == lock_over) begin
                st      = st_entry;
                n_tries = 0;
            end
        end
        case (st)
            st_open:    disp = disp_open;
            st_lockout: disp = {4'h0, to_bcd(secs)};
            default:    disp = shown;
        endcase
        return {disp, st == st_open, st == st_lockout, 3'(n_tries)};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_state();
        logic [16:0] exp;
        int          n;
        exp = expected_state(exp_secs);
        n = 0;
        @(negedge clk);
        while ({display, unlocked, locked_out, tries} !== exp && n < settle_max) begin
            @(negedge clk);
            n++;
        end
        if ({display, unlocked, locked_out, tries} !== exp) begin
            $display("ERROR: outputs did not settle after the last key press");
        end
        check_val("display", display, exp[16:5]);
        check_val("unlocked", unlocked, exp[4]);
        check_val("locked_out", locked_out, exp[3]);
        check_val("tries", tries, exp[2:0]);
    endtask

    task automatic press_vec(input logic [15:0] vec, input int hold);
        @(posedge clk);
        keys <= vec;
        repeat (hold) @(posedge clk);
        keys <= 16'h0000;
        repeat (2) @(posedge clk);  // idle gap so the next press counts
    endtask

    task automatic press(input key_t k, input int hold = 4);
        press_vec(key_vector(k), hold);
        presses.push_back(k);
        check_state();
    endtask

    task automatic press_invalid(input logic [15:0] vec);
        press_vec(vec, 4);
        presses.push_back(key_none);
        check_state();
    endtask

    // counts buzzer edges until it has been quiet for a while
    task automatic check_tone(input string what);
        int   n;
        int   quiet;
        int   edges;
        logic last;
        n     = 0;
        quiet = 0;
        edges = 0;
        last  = buzzer;
        while (quiet < 20 && n < 300) begin
            @(negedge clk);
            if (buzzer !== last) edges++;
            quiet = buzzer ? 0 : quiet + 1;
            last  = buzzer;
            n++;
        end
        if (n >= 300) begin
            errors++;
            $display("ERROR: buzzer never went quiet after the %s tone", what);
        end else if (edges < 2) begin
            errors++;
            $display("ERROR: buzzer did not toggle for the %s tone", what);
        end
    endtask

    task automatic wait_step(input int s);
        int n;
        n = 0;
        @(negedge clk);
        while (display[7:0] === to_bcd(s + 1) && n < 2 * tb_tps) begin
            @(negedge clk);
            n++;
        end
        if (n >= 2 * tb_tps) begin
            errors++;
            $display("ERROR: lockout countdown stuck at %0d seconds", s + 1);
        end
        exp_secs = s;
        check_val("display", display, {4'h0, to_bcd(s)});
        check_val("locked_out", locked_out, 1'b1);
    endtask

    task automatic wait_lockout_end();
        int n;
        n = 0;
        while (locked_out && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (locked_out) begin
            errors++;
            $display("ERROR: locked_out stayed high after the countdown reached zero");
        end
    endtask

    task automatic begin_test();
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - test_errors);
        end
    endtask

    initial begin
        int n;
        arst_n    = 1'b0;
        keys      = 16'h0000;
        lcg_state = 32'h00c1_23ad;
        exp_secs  = 0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        begin_test();
        check_state();
        check_val("buzzer", buzzer, 1'b0);
        end_test("reset values");

        begin_test();
        for (int r = 0; r < 4; r++) begin
            n = 1 + int'((lcg_next() >> 16) % 5);
            press(key_cancel);
            for (int i = 0; i < n; i++) begin
                press(key_t'((lcg_next() >> 16) % 10));
                if (i == 0) check_tone("click");
            end
        end
        press(key_cancel);
        press(4'd7, 12);  // long hold gives one digit only
        end_test("random digits");

        begin_test();
        press(key_cancel);
        press(tb_passcode[11:8]);
        press(tb_passcode[7:4]);
        press(tb_passcode[3:0]);
        press(key_enter);
        check_tone("pass");
        press(key_clear);
        end_test("correct code");

        begin_test();
        press(4'd1);
        press(4'd2);
        press(4'd3);
        press(key_enter);
        check_tone("fail");
        press(4'd5);
        press(key_cancel);
        press(key_clear);
        press(4'd4);
        press(key_enter);  // short entry also fails
        check_tone("fail");
        press(key_clear);
        end_test("wrong code");

        begin_test();
        exp_secs = tb_secs;
        press(key_enter);
        press(key_enter);
        press(key_enter);
        press(4'd5);  // ignored while locked out
        for (int s = tb_secs - 1; s >= 0; s--) begin
            wait_step(s);
        end
        wait_lockout_end();
        presses.push_back(lock_over);
        check_state();
        press(tb_passcode[11:8]);
        press(tb_passcode[7:4]);
        press(tb_passcode[3:0]);
        press(key_enter);
        press(key_clear);
        end_test("lockout");

        begin_test();
        press(4'd3);
        press_invalid(16'h0003);
        press_invalid(16'h0002);
        press_invalid(16'h0004);
        press_invalid(16'h0010);
        press_invalid(16'h8001);
        press(key_cancel);
        end_test("invalid keys");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* source/code_lock.sv */
`timescale 1ns/10ps

module code_lock import code_lock_pkg::*; #(
    parameter display_t passcode      = 12'h246,
    parameter int       max_tries     = 3,
    parameter int       lockout_secs  = 60,
    parameter int       ticks_per_sec = 50_000_000,
    parameter int       click_half    = 25_000,      // 1 kHz at 50 MHz
    parameter int       click_len     = 5_000_000,   // 100 ms
    parameter int       pass_half     = 12_500,
    parameter int       pass_len      = 25_000_000,
    parameter int       fail_half     = 50_000,
    parameter int       fail_len      = 30_000_000
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [15:0] keys,
    output display_t    display,
    output logic        unlocked,
    output logic        locked_out,
    output logic [2:0]  tries,
    output logic        buzzer
);

    logic       key_valid;
    key_t       key_code;
    logic       lock_start;
    logic       lock_done;
    bcd_t [1:0] secs_left;
    logic       sound_start;
    sound_t     sound_kind;

    key_decoder u_key_decoder (
        .clk       (clk),
        .arst_n    (arst_n),
        .keys      (keys),
        .key_valid (key_valid),
        .key_code  (key_code)
    );

    entry_controller #(
        .passcode  (passcode),
        .max_tries (max_tries)
    ) u_entry_controller (
        .clk         (clk),
        .arst_n      (arst_n),
        .key_valid   (key_valid),
        .key_code    (key_code),
        .secs_left   (secs_left),
        .lock_done   (lock_done),
        .display     (display),
        .unlocked    (unlocked),
        .locked_out  (locked_out),
        .tries       (tries),
        .lock_start  (lock_start),
        .sound_start (sound_start),
        .sound_kind  (sound_kind)
    );

    lockout_timer #(
        .lockout_secs  (lockout_secs),
        .ticks_per_sec (ticks_per_sec)
    ) u_lockout_timer (
        .clk        (clk),
        .arst_n     (arst_n),
        .lock_start (lock_start),
        .secs_left  (secs_left),
        .lock_done  (lock_done)
    );

    buzzer_driver #(
        .click_half (click_half),
        .click_len  (click_len),
        .pass_half  (pass_half),
        .pass_len   (pass_len),
        .fail_half  (fail_half),
        .fail_len   (fail_len)
    ) u_buzzer_driver (
        .clk         (clk),
        .arst_n      (arst_n),
        .sound_start (sound_start),
        .sound_kind  (sound_kind),
        .buzzer      (buzzer)
    );

endmodule

/* source/buzzer_driver.sv */
`timescale 1ns/10ps

module buzzer_driver import code_lock_pkg::*; #(
    parameter int click_half = 25_000,
    parameter int click_len  = 5_000_000,
    parameter int pass_half  = 12_500,
    parameter int pass_len   = 25_000_000,
    parameter int fail_half  = 50_000,
    parameter int fail_len   = 30_000_000
) (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   sound_start,
    input  sound_t sound_kind,
    output logic   buzzer
);

    function automatic int max3(input int a, input int b, input int c);
        int m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    localparam int half_w = $clog2(max3(click_half, pass_half, fail_half) + 1);
    localparam int len_w  = $clog2(max3(click_len, pass_len, fail_len) + 1);

    // fail pattern goes quiet over its middle third
    localparam logic [len_w-1:0] mute_lo = len_w'(fail_len / 3);
    localparam logic [len_w-1:0] mute_hi = len_w'((2 * fail_len) / 3);

    sound_t            kind;      // pattern being played
    logic              active;
    logic              tone;      // raw square wave
    logic              mute;
    logic [half_w-1:0] half_cnt;
    logic [half_w-1:0] half_sel;  // last count of a half period
    logic [len_w-1:0]  dur_cnt;
    logic [len_w-1:0]  len_sel;   // last count of the pattern

    always_comb begin
        case (kind)
            snd_pass: begin
                half_sel = half_w'(pass_half - 1);
                len_sel  = len_w'(pass_len - 1);
            end
            snd_fail: begin
                half_sel = half_w'(fail_half - 1);
                len_sel  = len_w'(fail_len - 1);
            end
            default: begin  // click and the unused code
                half_sel = half_w'(click_half - 1);
                len_sel  = len_w'(click_len - 1);
            end
        endcase
    end

    assign mute = (kind == snd_fail) && (dur_cnt >= mute_lo) && (dur_cnt < mute_hi);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            kind     <= snd_click;
            active   <= 1'b0;
            tone     <= 1'b0;
            half_cnt <= '0;
            dur_cnt  <= '0;
        end else if (sound_start) begin  // a new request cuts the old one short
            kind     <= sound_kind;
            active   <= 1'b1;
            tone     <= 1'b1;
            half_cnt <= '0;
            dur_cnt  <= '0;
        end else if (active) begin
            if (half_cnt == half_sel) begin
                half_cnt <= '0;
                tone     <= ~tone;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
            if (dur_cnt == len_sel) begin
                active <= 1'b0;  // pattern over
            end else begin
                dur_cnt <= dur_cnt + 1'b1;
            end
        end
    end

    assign buzzer = active && tone && !mute;

endmodule

/* source/lockout_timer.sv */
`timescale 1ns/10ps

module lockout_timer import code_lock_pkg::*; #(
    parameter int lockout_secs  = 60,
    parameter int ticks_per_sec = 50_000_000
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       lock_start,
    output bcd_t [1:0] secs_left,   // [1] tens, [0] units
    output logic       lock_done
);

    localparam int               pre_w      = $clog2(ticks_per_sec + 1);
    localparam logic [pre_w-1:0] pre_max    = pre_w'(ticks_per_sec - 1);
    localparam bcd_t             load_tens  = bcd_t'(lockout_secs / 10);
    localparam bcd_t             load_units = bcd_t'(lockout_secs % 10);

    logic [pre_w-1:0] prescale;  // cycles within the current second
    logic             running;
    logic             sec_tick;
    logic             last_sec;

    assign sec_tick = running && (prescale == pre_max);
    assign last_sec = (secs_left[1] == 4'd0) && (secs_left[0] <= 4'd1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running   <= 1'b0;
            prescale  <= '0;
            secs_left <= '0;
            lock_done <= 1'b0;
        end else begin
            lock_done <= 1'b0;
            if (lock_start) begin
                running   <= 1'b1;
                prescale  <= '0;
                secs_left <= {load_tens, load_units};
            end else if (sec_tick) begin
                prescale <= '0;
                if (last_sec) begin  // 1 -> 0 ends the lockout
                    running      <= 1'b0;
                    lock_done    <= 1'b1;
                    secs_left[0] <= 4'd0;
                end else if (secs_left[0] == 4'd0) begin
                    secs_left[0] <= 4'd9;  // borrow from tens
                    secs_left[1] <= secs_left[1] - 4'd1;
                end else begin
                    secs_left[0] <= secs_left[0] - 4'd1;
                end
            end else if (running) begin
                prescale <= prescale + 1'b1;
            end
        end
    end

endmodule

/* source/entry_controller.sv */
`timescale 1ns/10ps

module entry_controller import code_lock_pkg::*; #(
    parameter display_t passcode  = 12'h246,
    parameter int       max_tries = 3
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       key_valid,
    input  key_t       key_code,
    input  logic [7:0] secs_left,
    input  logic       lock_done,
    output display_t   display,
    output logic       unlocked,
    output logic       locked_out,
    output logic [2:0] tries,
    output logic       lock_start,
    output logic       sound_start,
    output sound_t     sound_kind
);

    lock_state_t state;
    display_t    entry;      // digits shifted in from the right
    logic [1:0]  digits;     // number of digits taken so far
    logic        is_digit;
    logic        code_ok;
    logic        last_try;

    assign is_digit = (key_code <= 4'd9);
    assign code_ok  = (digits == 2'd3) && (entry == passcode);
    assign last_try = (int'(tries) + 1 >= max_tries);  // this failure triggers lockout

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= st_entry;
            entry       <= disp_blank;
            digits      <= 2'd0;
            tries       <= 3'd0;
            lock_start  <= 1'b0;
            sound_start <= 1'b0;
            sound_kind  <= snd_click;
        end else begin
            lock_start  <= 1'b0;  // single-cycle requests
            sound_start <= 1'b0;

            case (state)
                st_entry: begin
                    if (key_valid) begin
                        if (is_digit) begin
                            sound_start <= 1'b1;
                            sound_kind  <= snd_click;
                            if (digits != 2'd3) begin  // fourth digit on is dropped
                                entry  <= {entry[7:0], key_code};
                                digits <= digits + 2'd1;
                            end
                        end else if (key_code == key_enter) begin
                            entry       <= disp_blank;
                            digits      <= 2'd0;
                            sound_start <= 1'b1;
                            if (code_ok) begin
                                state      <= st_open;
                                sound_kind <= snd_pass;
                            end else begin
                                sound_kind <= snd_fail;
                                if (last_try) begin
                                    state      <= st_lockout;
                                    tries      <= 3'd0;
                                    lock_start <= 1'b1;
                                end else begin
                                    tries <= tries + 3'd1;
                                end
                            end
                        end else if (key_code == key_cancel) begin
                            entry  <= disp_blank;
                            digits <= 2'd0;
                        end else if (key_code == key_clear) begin
                            entry  <= disp_blank;
                            digits <= 2'd0;
                            tries  <= 3'd0;
                        end
                    end
                end

                st_open: begin
                    // only clear relocks, everything else is ignored
                    if (key_valid && key_code == key_clear) begin
                        state  <= st_entry;
                        entry  <= disp_blank;
                        digits <= 2'd0;
                        tries  <= 3'd0;
                    end
                end

                st_lockout: begin
                    if (lock_done) begin  // keys are ignored until the countdown ends
                        state  <= st_entry;
                        entry  <= disp_blank;
                        digits <= 2'd0;
                        tries  <= 3'd0;
                    end
                end

                default: begin
                    state <= st_entry;
                end
            endcase
        end
    end

    always_comb begin
        case (state)
            st_open:    display = disp_open;
            st_lockout: display = {4'h0, secs_left};  // 0 then seconds remaining
            default:    display = entry;
        endcase
    end

    assign unlocked   = (state == st_open);
    assign locked_out = (state == st_lockout);

endmodule

/* source/key_decoder.sv */
`timescale 1ns/10ps

module key_decoder import code_lock_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [15:0] keys,
    output logic        key_valid,
    output key_t        key_code
);

    key_t dec_code;   // combinational decode of the raw vector
    key_t prev_code;  // decode seen on the last edge

    // bits 1, 2 and 4 are not wired to a key
    always_comb begin
        case (keys)
            16'h0001: dec_code = key_enter;
            16'h0008: dec_code = 4'd0;
            16'h0020: dec_code = 4'd3;
            16'h0040: dec_code = 4'd2;
            16'h0080: dec_code = 4'd1;
            16'h0100: dec_code = key_clear;   // clears entry and tries
            16'h0200: dec_code = 4'd6;
            16'h0400: dec_code = 4'd5;
            16'h0800: dec_code = 4'd4;
            16'h1000: dec_code = key_cancel;  // clears entry only
            16'h2000: dec_code = 4'd9;
            16'h4000: dec_code = 4'd8;
            16'h8000: dec_code = 4'd7;
            default:  dec_code = key_none;    // idle, multi-hot or unused bit
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prev_code <= key_none;
            key_valid <= 1'b0;
            key_code  <= key_none;
        end else begin
            prev_code <= dec_code;
            // only a step out of the idle code counts as a press
            key_valid <= (prev_code == key_none) && (dec_code != key_none);
            key_code  <= dec_code;
        end
    end

endmodule

/* source/code_lock_pkg.sv */
package code_lock_pkg;

    typedef logic [3:0]  bcd_t;      // one bcd digit or display glyph
    typedef logic [11:0] display_t;  // three nibbles, msb nibble leftmost
    typedef logic [3:0]  key_t;      // decoded key, 0..9 are digits

    // command keys
    localparam key_t key_enter  = 4'd10;
    localparam key_t key_cancel = 4'd11;
    localparam key_t key_clear  = 4'd12;
    localparam key_t key_none   = 4'd15;  // no key or invalid vector

    // display patterns
    localparam bcd_t     glyph_blank = 4'hF;  // dark digit
    localparam display_t disp_blank  = {glyph_blank, glyph_blank, glyph_blank};
    localparam display_t disp_open   = 12'hA55;  // reads as "ASS" on the segments

    typedef enum logic [1:0] {
        snd_click,  // short key feedback
        snd_pass,   // long steady tone
        snd_fail    // two low bursts
    } sound_t;

    typedef enum logic [1:0] {
        st_entry,
        st_open,
        st_lockout
    } lock_state_t;

endpackage
